//--- hdl/alu_pkg.sv
`default_nettype none

package alu_pkg;

  typedef logic [31:0] word_t;  // operand and result word
  typedef logic [11:0] op_t;    // one-hot operation code
  typedef logic [3:0]  tag_t;   // request tag, returned with the result

  // bit positions inside op_t
  localparam int op_add_bit  = 0;
  localparam int op_sub_bit  = 1;
  localparam int op_slt_bit  = 2;   // signed set less than
  localparam int op_sltu_bit = 3;   // unsigned set less than
  localparam int op_and_bit  = 4;
  localparam int op_nor_bit  = 5;
  localparam int op_or_bit   = 6;
  localparam int op_xor_bit  = 7;
  localparam int op_sll_bit  = 8;
  localparam int op_srl_bit  = 9;
  localparam int op_sra_bit  = 10;
  localparam int op_lui_bit  = 11;  // src2 passes straight through

endpackage

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

module alu (
  input  wire alu_pkg::op_t   alu_op,
  input  wire alu_pkg::word_t alu_src1,
  input  wire alu_pkg::word_t alu_src2,
  output alu_pkg::word_t      alu_result
);

  logic op_add;
  logic op_sub;
  logic op_slt;
  logic op_sltu;
  logic op_and;
  logic op_nor;
  logic op_or;
  logic op_xor;
  logic op_sll;
  logic op_srl;
  logic op_sra;
  logic op_lui;

  assign op_add  = alu_op[alu_pkg::op_add_bit];
  assign op_sub  = alu_op[alu_pkg::op_sub_bit];
  assign op_slt  = alu_op[alu_pkg::op_slt_bit];
  assign op_sltu = alu_op[alu_pkg::op_sltu_bit];
  assign op_and  = alu_op[alu_pkg::op_and_bit];
  assign op_nor  = alu_op[alu_pkg::op_nor_bit];
  assign op_or   = alu_op[alu_pkg::op_or_bit];
  assign op_xor  = alu_op[alu_pkg::op_xor_bit];
  assign op_sll  = alu_op[alu_pkg::op_sll_bit];
  assign op_srl  = alu_op[alu_pkg::op_srl_bit];
  assign op_sra  = alu_op[alu_pkg::op_sra_bit];
  assign op_lui  = alu_op[alu_pkg::op_lui_bit];

  // shared adder, subtract for sub and both compares
  logic           do_sub;
  alu_pkg::word_t adder_b;
  alu_pkg::word_t adder_sum;
  logic           adder_cout;

  assign do_sub  = op_sub | op_slt | op_sltu;
  assign adder_b = do_sub ? ~alu_src2 : alu_src2;
  assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {32'b0, do_sub};

  logic slt_bit;
  logic sltu_bit;

  // negative minus positive, or same signs and a negative difference
  assign slt_bit  = (alu_src1[31] & ~alu_src2[31])
                  | ((alu_src1[31] ~^ alu_src2[31]) & adder_sum[31]);
  assign sltu_bit = ~adder_cout;  // borrow out

  // shifts: src1 is the value, src2[4:0] the amount
  logic [4:0]     shamt;
  alu_pkg::word_t sll_result;
  logic [63:0]    sr64_result;

  assign shamt       = alu_src2[4:0];
  assign sll_result  = alu_src1 << shamt;
  assign sr64_result = {{32{op_sra & alu_src1[31]}}, alu_src1} >> shamt;

  // and-or merge, several code bits give the or of their results
  assign alu_result = ({32{op_add | op_sub}} & adder_sum)
                    | ({32{op_slt}}          & {31'b0, slt_bit})
                    | ({32{op_sltu}}         & {31'b0, sltu_bit})
                    | ({32{op_and}}          & (alu_src1 & alu_src2))
                    | ({32{op_nor}}          & ~(alu_src1 | alu_src2))
                    | ({32{op_or}}           & (alu_src1 | alu_src2))
                    | ({32{op_xor}}          & (alu_src1 ^ alu_src2))
                    | ({32{op_sll}}          & sll_result)
                    | ({32{op_srl | op_sra}} & sr64_result[31:0])
                    | ({32{op_lui}}          & alu_src2);

endmodule

`default_nettype wire

//--- hdl/alu_issue.sv
`default_nettype none

module alu_issue #(
  parameter int fifo_depth = 4
) (
  input  wire                 clk,
  input  wire                 rst_n,
  // request side
  input  wire                 in_valid,
  output logic                in_ready,
  input  wire alu_pkg::op_t   in_op,
  input  wire alu_pkg::word_t in_src1,
  input  wire alu_pkg::word_t in_src2,
  input  wire alu_pkg::tag_t  in_tag,
  // toward the result fifo
  output logic                push,
  output alu_pkg::word_t      push_result,
  output alu_pkg::tag_t       push_tag,
  input  wire                 credit_return
);

  localparam int credit_w = $clog2(fifo_depth + 1);

  logic [credit_w-1:0] credits;  // free fifo entries not yet claimed
  logic                accept;

  assign in_ready = (credits != '0);
  assign accept   = in_valid & in_ready;

  // written into the fifo on the accepting edge
  assign push     = accept;
  assign push_tag = in_tag;

  alu u_alu (
    .alu_op     (in_op),
    .alu_src1   (in_src1),
    .alu_src2   (in_src2),
    .alu_result (push_result)
  );

  // one credit spent per push, one back per credit_return
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= credit_w'(fifo_depth);
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/result_fifo.sv
`default_nettype none

module result_fifo #(
  parameter int fifo_depth = 4
) (
  input  wire                 clk,
  input  wire                 rst_n,
  // write side, overflow is prevented by the credit loop
  input  wire                 push,
  input  wire alu_pkg::word_t push_result,
  input  wire alu_pkg::tag_t  push_tag,
  // read side, first word fall through
  input  wire                 pop,
  output logic                not_empty,
  output alu_pkg::word_t      head_result,
  output alu_pkg::tag_t       head_tag,
  output logic                credit_return
);

  localparam int ptr_w = $clog2(fifo_depth);
  localparam int cnt_w = $clog2(fifo_depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(fifo_depth - 1);

  alu_pkg::word_t   mem_result [fifo_depth];
  alu_pkg::tag_t    mem_tag    [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  // wrap explicitly, depth need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    next_ptr = (p == last_ptr) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;  // one credit back per freed entry
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_result[wr_ptr] <= push_result;
      mem_tag[wr_ptr]    <= push_tag;
    end
  end

  assign not_empty   = (count != '0);
  assign head_result = mem_result[rd_ptr];
  assign head_tag    = mem_tag[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/result_writeback.sv
`default_nettype none

module result_writeback (
  input  wire                 clk,
  input  wire                 rst_n,
  // fifo head
  input  wire                 not_empty,
  input  wire alu_pkg::word_t head_result,
  input  wire alu_pkg::tag_t  head_tag,
  output logic                pop,
  // result port
  output logic                out_valid,
  input  wire                 out_ready,
  output alu_pkg::word_t      out_result,
  output alu_pkg::tag_t       out_tag
);

  logic reg_free;  // register empty or handed off this edge

  assign reg_free = ~out_valid | out_ready;
  assign pop      = not_empty & reg_free;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (reg_free) begin
      out_valid <= not_empty;
    end
  end

  // held steady while out_ready is low
  always_ff @(posedge clk) begin
    if (pop) begin
      out_result <= head_result;
      out_tag    <= head_tag;
    end
  end

endmodule

`default_nettype wire

//--- hdl/alu_unit_top.sv
`default_nettype none

module alu_unit_top #(
  parameter int fifo_depth = 4  // 2 or more
) (
  input  wire                 clk,
  input  wire                 rst_n,
  // request port
  input  wire                 in_valid,
  output logic                in_ready,
  input  wire alu_pkg::op_t   in_op,
  input  wire alu_pkg::word_t in_src1,
  input  wire alu_pkg::word_t in_src2,
  input  wire alu_pkg::tag_t  in_tag,
  // result port
  output logic                out_valid,
  input  wire                 out_ready,
  output alu_pkg::word_t      out_result,
  output alu_pkg::tag_t       out_tag
);

  // issue to fifo
  logic           push;
  alu_pkg::word_t push_result;
  alu_pkg::tag_t  push_tag;
  logic           credit_return;

  // fifo to writeback
  logic           pop;
  logic           not_empty;
  alu_pkg::word_t head_result;
  alu_pkg::tag_t  head_tag;

  alu_issue #(
    .fifo_depth (fifo_depth)
  ) u_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_op         (in_op),
    .in_src1       (in_src1),
    .in_src2       (in_src2),
    .in_tag        (in_tag),
    .push          (push),
    .push_result   (push_result),
    .push_tag      (push_tag),
    .credit_return (credit_return)
  );

  result_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .push          (push),
    .push_result   (push_result),
    .push_tag      (push_tag),
    .pop           (pop),
    .not_empty     (not_empty),
    .head_result   (head_result),
    .head_tag      (head_tag),
    .credit_return (credit_return)
  );

  result_writeback u_writeback (
    .clk         (clk),
    .rst_n       (rst_n),
    .not_empty   (not_empty),
    .head_result (head_result),
    .head_tag    (head_tag),
    .pop         (pop),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_result  (out_result),
    .out_tag     (out_tag)
  );

endmodule

`default_nettype wire

//--- sim/alu_unit_tb.sv
`default_nettype none

module alu_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int fifo_depth        = 4;
  localparam int directed_requests = 30;
  localparam int stall_cycles      = 20;
  localparam int random_requests   = 300;
  localparam int total_requests    = directed_requests + 1 + stall_cycles + random_requests;
  localparam int watchdog_cycles   = total_requests * 20 + 1000;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

  logic           clk;
  logic           rst_n;
  logic           in_valid;
  logic           in_ready;
  alu_pkg::op_t   in_op;
  alu_pkg::word_t in_src1;
  alu_pkg::word_t in_src2;
  alu_pkg::tag_t  in_tag;
  logic           out_valid;
  logic           out_ready;
  alu_pkg::word_t out_result;
  alu_pkg::tag_t  out_tag;

  logic [31:0]    lfsr_state = 32'd28;
  alu_pkg::word_t exp_result_q [$];  // expected results in request order
  alu_pkg::tag_t  exp_tag_q [$];
  int             accept_count = 0;
  int             out_count = 0;
  int             pass_count = 0;
  int             fail_count = 0;
  int             test_fail_base = 0;
  alu_pkg::tag_t  next_tag = '0;

  alu_unit_top #(
    .fifo_depth (fifo_depth)
  ) uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_op      (in_op),
    .in_src1    (in_src1),
    .in_src2    (in_src2),
    .in_tag     (in_tag),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .out_tag    (out_tag)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic alu_pkg::op_t one_hot(input int pos);
    alu_pkg::op_t op;
    op = '0;
    op[pos] = 1'b1;
    return op;
  endfunction

  // every selected operation ORed in, shifts take src2[4:0] as amount
  function automatic alu_pkg::word_t expected_result(input alu_pkg::op_t op,
                                                     input alu_pkg::word_t a,
                                                     input alu_pkg::word_t b);
    alu_pkg::word_t acc;
    alu_pkg::word_t r;
    logic [4:0]     amt;
    int             i;
    acc = '0;
    amt = b[4:0];
    for (i = 0; i < 12; i++) begin
      if (op[i]) begin
        case (i)
          alu_pkg::op_add_bit:  r = a + b;
          alu_pkg::op_sub_bit:  r = a - b;
          alu_pkg::op_slt_bit:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          alu_pkg::op_sltu_bit: r = (a < b) ? 32'd1 : 32'd0;
          alu_pkg::op_and_bit:  r = a & b;
          alu_pkg::op_nor_bit:  r = ~(a | b);
          alu_pkg::op_or_bit:   r = a | b;
          alu_pkg::op_xor_bit:  r = a ^ b;
          alu_pkg::op_sll_bit:  r = a << amt;
          alu_pkg::op_srl_bit:  r = a >> amt;
          alu_pkg::op_sra_bit:  r = $signed(a) >>> amt;
          default:              r = b;  // lui
        endcase
        acc = acc | r;
      end
    end
    return acc;
  endfunction

  task automatic check_word(input string name, input alu_pkg::word_t expected,
                            input alu_pkg::word_t actual);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_tag(input string name, input alu_pkg::tag_t expected,
                           input alu_pkg::tag_t actual);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, fail_count - test_fail_base);
    test_fail_base = fail_count;
  endtask

  // record each accepted request, sampled before the edge updates
  always @(posedge clk) begin
    if (rst_n && in_valid && in_ready) begin
      exp_result_q.push_back(expected_result(in_op, in_src1, in_src2));
      exp_tag_q.push_back(in_tag);
      accept_count++;
    end
  end

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      out_count++;
      if (exp_result_q.size() == 0) begin
        $display("output transfer at %0d ns with no request outstanding", $time);
        fail_count++;
      end else begin
        check_word("out_result", exp_result_q.pop_front(), out_result);
        check_tag("out_tag", exp_tag_q.pop_front(), out_tag);
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("Something failed");
    $finish;
  end

  // called on a rising edge, returns on the edge that takes the request
  task automatic drive_request(input alu_pkg::op_t op, input alu_pkg::word_t a,
                               input alu_pkg::word_t b, input alu_pkg::tag_t tag);
    in_valid <= 1'b1;
    in_op    <= op;
    in_src1  <= a;
    in_src2  <= b;
    in_tag   <= tag;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
  endtask

  task automatic send_request(input alu_pkg::op_t op, input alu_pkg::word_t a,
                              input alu_pkg::word_t b);
    drive_request(op, a, b, next_tag);
    next_tag++;
  endtask

  task automatic load_random_request();
    int idx;
    idx = int'(rand_bits(4) % 12);
    in_valid <= 1'b1;
    in_op    <= one_hot(idx);
    in_src1  <= rand_bits(32);
    in_src2  <= rand_bits(32);
    in_tag   <= alu_pkg::tag_t'(rand_bits(4));
  endtask

  task automatic wait_drained(input string name, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (exp_result_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_result_q.size() != 0) begin
      $display("%s: %0d results never came out", name, exp_result_q.size());
      fail_count++;
    end
  endtask

  task automatic check_reset_state();
    int k;
    for (k = 0; k < 5; k++) begin
      @(posedge clk);
      if (k == 4) rst_n <= 1'b1;  // released after the fifth edge
      @(negedge clk);
      check_flag("out_valid", 1'b0, out_valid);
      check_flag("in_ready", 1'b1, in_ready);
    end
    @(posedge clk);
    @(negedge clk);
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("in_ready", 1'b1, in_ready);
    report_test("reset state");
  endtask

  task automatic exercise_directed_ops();
    @(posedge clk);
    out_ready <= 1'b1;
    send_request(one_hot(alu_pkg::op_add_bit), 32'h7fff_ffff, 32'h0000_0001);
    send_request(one_hot(alu_pkg::op_add_bit), 32'hffff_ffff, 32'h0000_0001);
    send_request(one_hot(alu_pkg::op_sub_bit), 32'h0000_0000, 32'h0000_0001);
    send_request(one_hot(alu_pkg::op_sub_bit), 32'h8000_0000, 32'h0000_0001);
    send_request(one_hot(alu_pkg::op_slt_bit), 32'h8000_0000, 32'h7fff_ffff);
    send_request(one_hot(alu_pkg::op_slt_bit), 32'h7fff_ffff, 32'h8000_0000);
    send_request(one_hot(alu_pkg::op_slt_bit), 32'hffff_ffff, 32'h0000_0000);
    send_request(one_hot(alu_pkg::op_sltu_bit), 32'h0000_0000, 32'hffff_ffff);
    send_request(one_hot(alu_pkg::op_sltu_bit), 32'hffff_ffff, 32'h0000_0000);
    send_request(one_hot(alu_pkg::op_sltu_bit), 32'h8000_0000, 32'h7fff_ffff);
    send_request(one_hot(alu_pkg::op_and_bit), 32'ha5a5_a5a5, 32'h0ff0_0ff0);
    send_request(one_hot(alu_pkg::op_nor_bit), 32'ha5a5_a5a5, 32'h0ff0_0ff0);
    send_request(one_hot(alu_pkg::op_or_bit), 32'ha5a5_a5a5, 32'h0ff0_0ff0);
    send_request(one_hot(alu_pkg::op_xor_bit), 32'ha5a5_a5a5, 32'h0ff0_0ff0);
    send_request(one_hot(alu_pkg::op_sll_bit), 32'h8000_0001, 32'h0000_0000);
    send_request(one_hot(alu_pkg::op_sll_bit), 32'h8000_0001, 32'h0000_0001);
    send_request(one_hot(alu_pkg::op_sll_bit), 32'h8000_0001, 32'h0000_001f);
    send_request(one_hot(alu_pkg::op_sll_bit), 32'h1234_5678, 32'hffff_ffe4);  // amount 4
    send_request(one_hot(alu_pkg::op_srl_bit), 32'h8000_0000, 32'h0000_0000);
    send_request(one_hot(alu_pkg::op_srl_bit), 32'h8000_0000, 32'h0000_0001);
    send_request(one_hot(alu_pkg::op_srl_bit), 32'h8000_0000, 32'h0000_001f);
    send_request(one_hot(alu_pkg::op_srl_bit), 32'hf000_0000, 32'h0000_0123);  // amount 3
    send_request(one_hot(alu_pkg::op_sra_bit), 32'h8000_0000, 32'h0000_0001);
    send_request(one_hot(alu_pkg::op_sra_bit), 32'h8000_0000, 32'h0000_001f);
    send_request(one_hot(alu_pkg::op_sra_bit), 32'hffff_fff0, 32'h0000_0004);
    send_request(one_hot(alu_pkg::op_sra_bit), 32'h7fff_fff0, 32'hffff_ffe3);
    send_request(one_hot(alu_pkg::op_lui_bit), 32'hffff_ffff, 32'h0000_0000);
    send_request(one_hot(alu_pkg::op_lui_bit), 32'h0000_0000, 32'h1234_5000);
    send_request(12'h000, 32'hdead_beef, 32'hcafe_f00d);  // no operation selected
    send_request(one_hot(alu_pkg::op_add_bit) | one_hot(alu_pkg::op_xor_bit),
                 32'h0000_00f0, 32'h0000_0f0f);
    in_valid <= 1'b0;
    wait_drained("directed", 100);
    report_test("directed operations");
  endtask

  task automatic measure_latency();
    int lat;
    @(posedge clk);
    drive_request(one_hot(alu_pkg::op_xor_bit), 32'h1234_5678, 32'h0f0f_0f0f, 4'ha);
    in_valid <= 1'b0;
    lat = 0;  // the handshake cycle is cycle 0
    do begin
      @(negedge clk);
      lat++;
    end while (!out_valid && lat < 10);
    if (lat != 2) begin
      $display("out_valid came %0d cycles after acceptance instead of 2", lat);
      fail_count++;
    end else begin
      pass_count++;
    end
    wait_drained("latency", 20);
    report_test("latency");
  endtask

  task automatic fill_during_stall();
    int base;
    int c;
    @(posedge clk);
    base = accept_count;
    out_ready <= 1'b0;
    load_random_request();
    for (c = 0; c < stall_cycles; c++) begin
      @(posedge clk);
      if (in_ready) load_random_request();  // previous one went in on this edge
    end
    in_valid <= 1'b0;
    @(negedge clk);
    if (accept_count - base != fifo_depth + 1) begin
      $display("stall accepted %0d requests instead of %0d", accept_count - base,
               fifo_depth + 1);
      fail_count++;
    end else begin
      pass_count++;
    end
    check_flag("in_ready", 1'b0, in_ready);
    @(posedge clk);
    out_ready <= 1'b1;
    wait_drained("stall", 50);
    report_test("stall capacity");
  endtask

  task automatic stream_random();
    int base;
    int sent;
    base = out_count;
    sent = 0;
    while (sent < random_requests) begin
      @(posedge clk);
      if (in_valid && in_ready) sent++;
      out_ready <= (rand_bits(1) != 0);
      if (sent < random_requests && (!in_valid || in_ready)) begin
        if (rand_bits(2) != 0) load_random_request();
        else in_valid <= 1'b0;  // gap
      end
    end
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    wait_drained("random", 100);
    if (out_count - base != random_requests) begin
      $display("random stream delivered %0d results instead of %0d", out_count - base,
               random_requests);
      fail_count++;
    end else begin
      pass_count++;
    end
    report_test("random stream");
  endtask

  initial begin
    rst_n     <= 1'b0;
    in_valid  <= 1'b0;
    in_op     <= '0;
    in_src1   <= '0;
    in_src2   <= '0;
    in_tag    <= '0;
    out_ready <= 1'b0;
    check_reset_state();
    exercise_directed_ops();
    measure_latency();
    fill_during_stall();
    stream_random();
    $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hdl/alu_pkg.sv
hdl/alu.sv
hdl/alu_issue.sv
hdl/result_fifo.sv
hdl/result_writeback.sv
hdl/alu_unit_top.sv
sim/alu_unit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module alu_unit_tb \
  --Mdir obj_dir -o alu_unit_sim -f files.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/alu_unit_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
